// File: Makefile
# Verilator build for the DLX pipeline testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= dlx_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Regression failed
PASS_MSG  ?= Regression passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := dv/dlx_prog.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/dlx_prog.svh
`ifndef DLX_PROG_SVH
`define DLX_PROG_SVH

// columns: test name, instruction word, store expected, store address, store data
// itype(op, rs1, rd field, imm16) and rtype(func, rs1, rs2, rd)

task automatic load_program();
    ////////////////////
    // immediates, sign extended
    ////////////////////
    add_row("addi_pos", itype(dlx_pkg::OP_ADDI, 5'd0, 5'd1, 16'h0005), 1'b0, '0, '0);
    // data from the previous instruction
    add_row("sw_memfwd", itype(dlx_pkg::OP_SW, 5'd0, 5'd1, 16'h0000), 1'b1, 'h00, 'h5);
    add_row("addi_neg", itype(dlx_pkg::OP_ADDI, 5'd0, 5'd2, 16'hfffd), 1'b0, '0, '0);
    add_row("nop", NOP_WORD, 1'b0, '0, '0);
    add_row("sw_wbfwd", itype(dlx_pkg::OP_SW, 5'd0, 5'd2, 16'h0004), 1'b1, 'h04, 'hfffffffd);
    add_row("ori_neg", itype(dlx_pkg::OP_ORI, 5'd0, 5'd3, 16'h8001), 1'b0, '0, '0);
    add_row("nop", NOP_WORD, 1'b0, '0, '0);
    add_row("nop", NOP_WORD, 1'b0, '0, '0);
    // r3 comes through the regfile bypass
    add_row("sw_bypass", itype(dlx_pkg::OP_SW, 5'd0, 5'd3, 16'h0008), 1'b1, 'h08, 'hffff8001);

    ////////////////////
    // back to back, mem stage path
    ////////////////////
    add_row("add_r4", rtype(dlx_pkg::FN_ADD, 5'd1, 5'd2, 5'd4), 1'b0, '0, '0);
    add_row("sub_r5", rtype(dlx_pkg::FN_SUB, 5'd4, 5'd1, 5'd5), 1'b0, '0, '0);
    add_row("and_r6", rtype(dlx_pkg::FN_AND, 5'd5, 5'd3, 5'd6), 1'b0, '0, '0);
    add_row("or_r7", rtype(dlx_pkg::FN_OR, 5'd6, 5'd4, 5'd7), 1'b0, '0, '0);
    // negative vs 5, signed
    add_row("slt_r8", rtype(dlx_pkg::FN_SLT, 5'd7, 5'd1, 5'd8), 1'b0, '0, '0);
    add_row("sw_slt_m", itype(dlx_pkg::OP_SW, 5'd0, 5'd8, 16'h000c), 1'b1, 'h0c, 'h1);
    add_row("sw_or_m", itype(dlx_pkg::OP_SW, 5'd0, 5'd7, 16'h0010), 1'b1, 'h10, 'hffff8003);
    add_row("sw_add_m", itype(dlx_pkg::OP_SW, 5'd0, 5'd4, 16'h0014), 1'b1, 'h14, 'h2);
    add_row("sw_sub_m", itype(dlx_pkg::OP_SW, 5'd0, 5'd5, 16'h0018), 1'b1, 'h18, 'hfffffffd);
    add_row("sw_and_m", itype(dlx_pkg::OP_SW, 5'd0, 5'd6, 16'h001c), 1'b1, 'h1c, 'hffff8001);

    ////////////////////
    // one slot apart, write-back path
    ////////////////////
    add_row("subi_r9", itype(dlx_pkg::OP_SUBI, 5'd1, 5'd9, 16'h0007), 1'b0, '0, '0);
    add_row("addi_r20", itype(dlx_pkg::OP_ADDI, 5'd0, 5'd20, 16'h0064), 1'b0, '0, '0);
    add_row("add_r10", rtype(dlx_pkg::FN_ADD, 5'd9, 5'd1, 5'd10), 1'b0, '0, '0);
    add_row("andi_r21", itype(dlx_pkg::OP_ANDI, 5'd20, 5'd21, 16'h00f0), 1'b0, '0, '0);
    add_row("sub_r11", rtype(dlx_pkg::FN_SUB, 5'd10, 5'd9, 5'd11), 1'b0, '0, '0);
    add_row("nop", NOP_WORD, 1'b0, '0, '0);
    add_row("and_r12", rtype(dlx_pkg::FN_AND, 5'd11, 5'd10, 5'd12), 1'b0, '0, '0);
    add_row("nop", NOP_WORD, 1'b0, '0, '0);
    add_row("or_r13", rtype(dlx_pkg::FN_OR, 5'd12, 5'd9, 5'd13), 1'b0, '0, '0);
    add_row("nop", NOP_WORD, 1'b0, '0, '0);
    // -2 < -1
    add_row("slt_r14", rtype(dlx_pkg::FN_SLT, 5'd9, 5'd13, 5'd14), 1'b0, '0, '0);
    add_row("nop", NOP_WORD, 1'b0, '0, '0);
    add_row("sw_slt_w", itype(dlx_pkg::OP_SW, 5'd0, 5'd14, 16'h0020), 1'b1, 'h20, 'h1);
    add_row("sw_or_w", itype(dlx_pkg::OP_SW, 5'd0, 5'd13, 16'h0024), 1'b1, 'h24, 'hffffffff);
    add_row("sw_and_w", itype(dlx_pkg::OP_SW, 5'd0, 5'd12, 16'h0028), 1'b1, 'h28, 'h1);
    add_row("sw_sub_w", itype(dlx_pkg::OP_SW, 5'd0, 5'd11, 16'h002c), 1'b1, 'h2c, 'h5);
    add_row("sw_add_w", itype(dlx_pkg::OP_SW, 5'd0, 5'd10, 16'h0030), 1'b1, 'h30, 'h3);
    add_row("sw_andi", itype(dlx_pkg::OP_SW, 5'd0, 5'd21, 16'h0034), 1'b1, 'h34, 'h60);

    ////////////////////
    // register zero
    ////////////////////
    add_row("addi_r0", itype(dlx_pkg::OP_ADDI, 5'd0, 5'd0, 16'h004d), 1'b0, '0, '0);
    add_row("add_r15", rtype(dlx_pkg::FN_ADD, 5'd0, 5'd1, 5'd15), 1'b0, '0, '0);
    add_row("sw_r15", itype(dlx_pkg::OP_SW, 5'd0, 5'd15, 16'h0038), 1'b1, 'h38, 'h5);
    add_row("sw_r0", itype(dlx_pkg::OP_SW, 5'd0, 5'd0, 16'h003c), 1'b1, 'h3c, 'h0);

    ////////////////////
    // load-use
    ////////////////////
    add_row("lw_r16", itype(dlx_pkg::OP_LW, 5'd0, 5'd16, 16'h0004), 1'b0, '0, '0);
    add_row("add_r17", rtype(dlx_pkg::FN_ADD, 5'd16, 5'd1, 5'd17), 1'b0, '0, '0);
    add_row("sw_ldsum", itype(dlx_pkg::OP_SW, 5'd0, 5'd17, 16'h0040), 1'b1, 'h40, 'h2);
    // loaded word straight into store data
    add_row("lw_r18", itype(dlx_pkg::OP_LW, 5'd0, 5'd18, 16'h0008), 1'b0, '0, '0);
    add_row("sw_ldfwd", itype(dlx_pkg::OP_SW, 5'd0, 5'd18, 16'h0044), 1'b1, 'h44, 'hffff8001);
    // 100 - 28
    add_row("sw_negoff", itype(dlx_pkg::OP_SW, 5'd20, 5'd1, 16'hffe4), 1'b1, 'h48, 'h5);

    // drain
    add_row("nop", NOP_WORD, 1'b0, '0, '0);
    add_row("nop", NOP_WORD, 1'b0, '0, '0);
    add_row("nop", NOP_WORD, 1'b0, '0, '0);
    add_row("nop", NOP_WORD, 1'b0, '0, '0);
endtask

`endif

// File: dv/dlx_tb.sv
`default_nettype none

module dlx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////
    // constants
    ////////////////////
    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 4;
    localparam int MEM_DEPTH      = 64;
    localparam int MAX_ROWS       = 64;
    localparam int TIMEOUT_CYCLES = 50;
    localparam int QUIET_CYCLES   = 10;
    localparam dlx_pkg::word_t NOP_WORD = '0;

    logic               clk = 1'b0;
    logic               rst;
    dlx_pkg::word_t     imem_addr;
    dlx_pkg::word_t     imem_data;
    dlx_pkg::dmem_req_t dmem_req;
    dlx_pkg::word_t     dmem_rdata;

    // program table
    string          row_name  [MAX_ROWS];
    dlx_pkg::word_t row_instr [MAX_ROWS];
    bit             row_store [MAX_ROWS];
    dlx_pkg::word_t row_addr  [MAX_ROWS];
    dlx_pkg::word_t row_data  [MAX_ROWS];
    int             num_rows = 0;

    dlx_pkg::word_t dmem [MEM_DEPTH];

    ////////////////////
    // helpers
    ////////////////////
    // byte address to word number
    function automatic int word_of(dlx_pkg::word_t a);
        return int'(a[0:29]);
    endfunction

    function automatic dlx_pkg::word_t rtype(logic [0:dlx_pkg::FN_W-1] fn,
                                             dlx_pkg::reg_idx_t rs1,
                                             dlx_pkg::reg_idx_t rs2,
                                             dlx_pkg::reg_idx_t rd);
        return {dlx_pkg::OP_RTYPE, rs1, rs2, rd, fn};
    endfunction

    // rt is the rd field and the store data for sw
    function automatic dlx_pkg::word_t itype(logic [0:dlx_pkg::OP_W-1] op,
                                             dlx_pkg::reg_idx_t rs1,
                                             dlx_pkg::reg_idx_t rt,
                                             logic [0:dlx_pkg::IMM_W-1] imm);
        return {op, rs1, rt, imm};
    endfunction

    task automatic stop_on_error();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(string name, dlx_pkg::word_t expected,
                               dlx_pkg::word_t actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic add_row(string name, dlx_pkg::word_t instr, bit store,
                           dlx_pkg::word_t addr, dlx_pkg::word_t data);
        if (num_rows >= MAX_ROWS) begin
            $display("program table holds more than %0d rows", MAX_ROWS);
            stop_on_error();
        end else begin
            row_name[num_rows]  = name;
            row_instr[num_rows] = instr;
            row_store[num_rows] = store;
            row_addr[num_rows]  = addr;
            row_data[num_rows]  = data;
            num_rows++;
        end
    endtask

    // next cycle with the write strobe sampled mid cycle
    task automatic wait_store(string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!dmem_req.we) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                $display("timeout: no store for %s within %0d cycles", name, TIMEOUT_CYCLES);
                stop_on_error();
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    `include "dlx_prog.svh"

    ////////////////////
    // DUT and memories
    ////////////////////
    dlx_core UUT (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // instruction rom returns nop past the table
    always_comb begin
        if (word_of(imem_addr) < num_rows) begin
            imem_data = row_instr[word_of(imem_addr)];
        end else begin
            imem_data = NOP_WORD;
        end
    end

    // data ram cleared during reset and written on the strobe edge
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (dmem_req.we) begin
            dmem[word_of(dmem_req.addr) % MEM_DEPTH] <= dmem_req.wdata;
        end
    end

    always_comb begin
        dmem_rdata = dmem[word_of(dmem_req.addr) % MEM_DEPTH];
    end

    ////////////////////
    // sequence
    ////////////////////
    initial begin
        rst <= 1'b1;
        load_program();
        // strobe stays low and pc sits at zero in reset
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            @(negedge clk);
            check_value("reset_we", '0, dlx_pkg::word_t'(dmem_req.we));
            check_value("reset_pc", '0, imem_addr);
        end
        @(posedge clk);
        rst <= 1'b0;

        // fetch starts at address zero
        @(negedge clk);
        check_value("first_fetch", '0, imem_addr);
        check_value("first_we", '0, dlx_pkg::word_t'(dmem_req.we));

        // stores arrive in table order
        for (int r = 0; r < num_rows; r++) begin
            if (row_store[r]) begin
                wait_store(row_name[r]);
                check_value({row_name[r], "_addr"}, row_addr[r], dmem_req.addr);
                check_value({row_name[r], "_data"}, row_data[r], dmem_req.wdata);
            end
        end

        // nothing after the last store
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            check_value("extra_store", '0, dlx_pkg::word_t'(dmem_req.we));
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/dlx_core.sv
`default_nettype none

module dlx_core (
    input  wire logic            clk,
    input  wire logic            rst,
    output dlx_pkg::word_t       imem_addr,
    input  wire dlx_pkg::word_t  imem_data,
    output dlx_pkg::dmem_req_t   dmem_req,
    input  wire dlx_pkg::word_t  dmem_rdata
);

    // fetch to decode
    dlx_pkg::instr_t   if_instr;
    logic              stall;

    // decode to register file
    dlx_pkg::reg_idx_t ra;
    dlx_pkg::reg_idx_t rb;
    dlx_pkg::word_t    rd_a;
    dlx_pkg::word_t    rd_b;

    // stage payloads
    dlx_pkg::id_ex_t   id_ex;
    dlx_pkg::ex_mem_t  ex_mem;
    dlx_pkg::wb_t      wb;

    ////////////////////
    // stages
    ////////////////////
    dlx_fetch u_fetch (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .imem_data (imem_data),
        .imem_addr (imem_addr),
        .if_instr  (if_instr),
        .if_pc     ()
    );

    dlx_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .if_instr (if_instr),
        .rd_a     (rd_a),
        .rd_b     (rd_b),
        .ra       (ra),
        .rb       (rb),
        .stall    (stall),
        .id_ex    (id_ex)
    );

    // write and read bypass both from wb
    dlx_regfile u_regfile (
        .clk  (clk),
        .rst  (rst),
        .ra   (ra),
        .rb   (rb),
        .wb   (wb),
        .rd_a (rd_a),
        .rd_b (rd_b)
    );

    dlx_execute u_execute (
        .clk    (clk),
        .rst    (rst),
        .id_ex  (id_ex),
        .wb     (wb),
        .ex_mem (ex_mem)
    );

    dlx_writeback u_writeback (
        .clk        (clk),
        .rst        (rst),
        .ex_mem     (ex_mem),
        .dmem_rdata (dmem_rdata),
        .wb         (wb)
    );

    ////////////////////
    // data memory request
    ////////////////////
    assign dmem_req.addr  = ex_mem.alu_result;
    assign dmem_req.wdata = ex_mem.store_data;
    assign dmem_req.we    = ex_mem.mem_write;

endmodule

`default_nettype wire

// File: hw/dlx_decode.sv
`default_nettype none

module dlx_decode (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire dlx_pkg::instr_t   if_instr,
    input  wire dlx_pkg::word_t    rd_a,
    input  wire dlx_pkg::word_t    rd_b,
    output dlx_pkg::reg_idx_t      ra,
    output dlx_pkg::reg_idx_t      rb,
    output logic                   stall,
    output dlx_pkg::id_ex_t        id_ex
);

    dlx_pkg::ctrl_t    ctrl;
    dlx_pkg::id_ex_t   id_ex_d;
    dlx_pkg::reg_idx_t dest;
    logic              known;
    logic              uses_rs2;
    logic              load_in_ex;

    // source fields, same bit positions in both formats
    // rb is the store data register for sw
    assign ra = if_instr.r_fmt.rs1;
    assign rb = if_instr.r_fmt.rs2;

    ////////////////////
    // control decode
    ////////////////////
    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = dlx_pkg::ALU_ADD;
        known       = 1'b1;
        uses_rs2    = 1'b0;
        case (if_instr.r_fmt.opcode)
            dlx_pkg::OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                uses_rs2       = 1'b1;
                case (if_instr.r_fmt.func)
                    dlx_pkg::FN_ADD: ctrl.alu_op = dlx_pkg::ALU_ADD;
                    dlx_pkg::FN_SUB: ctrl.alu_op = dlx_pkg::ALU_SUB;
                    dlx_pkg::FN_AND: ctrl.alu_op = dlx_pkg::ALU_AND;
                    dlx_pkg::FN_OR:  ctrl.alu_op = dlx_pkg::ALU_OR;
                    dlx_pkg::FN_SLT: ctrl.alu_op = dlx_pkg::ALU_SLT;
                    default: begin
                        // unknown function, nop
                        ctrl.reg_write = 1'b0;
                        uses_rs2       = 1'b0;
                        known          = 1'b0;
                    end
                endcase
            end
            dlx_pkg::OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
            end
            dlx_pkg::OP_SUBI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = dlx_pkg::ALU_SUB;
            end
            dlx_pkg::OP_ANDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = dlx_pkg::ALU_AND;
            end
            dlx_pkg::OP_ORI: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.alu_op    = dlx_pkg::ALU_OR;
            end
            dlx_pkg::OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.use_imm    = 1'b1;
            end
            dlx_pkg::OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                uses_rs2       = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // destination by format, zero when nothing is written
    always_comb begin
        dest = (if_instr.r_fmt.opcode == dlx_pkg::OP_RTYPE) ? if_instr.r_fmt.rd
                                                            : if_instr.i_fmt.rd;
        if (!ctrl.reg_write) begin
            dest = '0;
        end
    end

    // load now in execute feeding a source here
    assign load_in_ex = id_ex.ctrl.mem_to_reg && (id_ex.rd != '0);
    assign stall = load_in_ex && ((known && (ra == id_ex.rd)) ||
                                  (uses_rs2 && (rb == id_ex.rd)));

    always_comb begin
        id_ex_d.ctrl     = ctrl;
        id_ex_d.op_a     = rd_a;
        id_ex_d.op_b     = rd_b;
        // sign extend, msb is bit 0
        id_ex_d.imm      = {{(dlx_pkg::WORD_W - dlx_pkg::IMM_W){if_instr.i_fmt.imm16[0]}},
                            if_instr.i_fmt.imm16};
        id_ex_d.rd       = dest;
        id_ex_d.rs1      = ra;
        id_ex_d.rs2      = rb;
        id_ex_d.uses_rs2 = uses_rs2;
    end

    ////////////////////
    // id/ex register
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.ctrl <= '0;
        end else if (stall) begin
            // bubble into execute
            id_ex.ctrl <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/dlx_execute.sv
`default_nettype none

module dlx_execute (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire dlx_pkg::id_ex_t  id_ex,
    input  wire dlx_pkg::wb_t     wb,
    output dlx_pkg::ex_mem_t      ex_mem
);

    dlx_pkg::ex_mem_t ex_mem_d;
    dlx_pkg::word_t   fwd_a;
    dlx_pkg::word_t   fwd_b;
    dlx_pkg::word_t   alu_b;
    dlx_pkg::word_t   result;
    logic             mem_fwd_ok;

    ////////////////////
    // forwarding
    ////////////////////
    // loads in mem have no data yet, stall covers them
    assign mem_fwd_ok = ex_mem.reg_write && !ex_mem.mem_to_reg && (ex_mem.rd != '0);

    // mem stage first, then write-back
    always_comb begin
        if (mem_fwd_ok && (ex_mem.rd == id_ex.rs1)) begin
            fwd_a = ex_mem.alu_result;
        end else if (wb.we && (wb.rd == id_ex.rs1)) begin
            fwd_a = wb.value;
        end else begin
            fwd_a = id_ex.op_a;
        end
    end

    // second source, also the sw data
    always_comb begin
        if (id_ex.uses_rs2 && mem_fwd_ok && (ex_mem.rd == id_ex.rs2)) begin
            fwd_b = ex_mem.alu_result;
        end else if (id_ex.uses_rs2 && wb.we && (wb.rd == id_ex.rs2)) begin
            fwd_b = wb.value;
        end else begin
            fwd_b = id_ex.op_b;
        end
    end

    assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b;

    ////////////////////
    // alu
    ////////////////////
    always_comb begin
        case (id_ex.ctrl.alu_op)
            dlx_pkg::ALU_ADD: result = fwd_a + alu_b;
            dlx_pkg::ALU_SUB: result = fwd_a - alu_b;
            dlx_pkg::ALU_AND: result = fwd_a & alu_b;
            dlx_pkg::ALU_OR:  result = fwd_a | alu_b;
            // signed compare
            dlx_pkg::ALU_SLT: result = ($signed(fwd_a) < $signed(alu_b)) ?
                                       dlx_pkg::word_t'(1) : '0;
            default:          result = fwd_a + alu_b;
        endcase
    end

    always_comb begin
        ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
        ex_mem_d.mem_to_reg = id_ex.ctrl.mem_to_reg;
        ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
        ex_mem_d.rd         = id_ex.rd;
        ex_mem_d.alu_result = result;
        ex_mem_d.store_data = fwd_b;
    end

    // ex/mem register
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.reg_write  <= 1'b0;
            ex_mem.mem_to_reg <= 1'b0;
            ex_mem.mem_write  <= 1'b0;
        end else begin
            ex_mem <= ex_mem_d;
        end
    end

endmodule

`default_nettype wire

// File: hw/dlx_fetch.sv
`default_nettype none

module dlx_fetch (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            stall,
    input  wire dlx_pkg::word_t  imem_data,
    output dlx_pkg::word_t       imem_addr,
    output dlx_pkg::instr_t      if_instr,
    output dlx_pkg::word_t       if_pc
);

    dlx_pkg::word_t pc;

    // instruction memory answers the pc in the same cycle
    assign imem_addr = pc;

    ////////////////////
    // pc and if/id register
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            if_instr <= dlx_pkg::NOP;
        end else if (!stall) begin
            pc       <= pc + dlx_pkg::PC_STEP;
            if_instr <= dlx_pkg::instr_t'(imem_data);
            // pc of the word now held for decode
            if_pc    <= pc;
        end
        // load-use stall: pc and fetched word both hold
    end

endmodule

`default_nettype wire

// File: hw/dlx_pkg.sv
`default_nettype none

package dlx_pkg;

    ////////////////////
    // widths
    ////////////////////
    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int OP_W     = 6;
    localparam int FN_W     = 11;
    localparam int IMM_W    = 16;
    localparam int NUM_REGS = 32;

    typedef logic [0:WORD_W-1] word_t;
    typedef logic [0:REG_W-1]  reg_idx_t;

    // byte addressed pc, one word per step
    localparam word_t PC_STEP = word_t'(4);

    // opcodes
    localparam logic [0:OP_W-1] OP_RTYPE = 6'h00;
    localparam logic [0:OP_W-1] OP_ADDI  = 6'h08;
    localparam logic [0:OP_W-1] OP_SUBI  = 6'h0a;
    localparam logic [0:OP_W-1] OP_ANDI  = 6'h0c;
    localparam logic [0:OP_W-1] OP_ORI   = 6'h0d;
    localparam logic [0:OP_W-1] OP_LW    = 6'h23;
    localparam logic [0:OP_W-1] OP_SW    = 6'h2b;

    // r-type function codes
    localparam logic [0:FN_W-1] FN_ADD = 11'h020;
    localparam logic [0:FN_W-1] FN_SUB = 11'h022;
    localparam logic [0:FN_W-1] FN_AND = 11'h024;
    localparam logic [0:FN_W-1] FN_OR  = 11'h025;
    localparam logic [0:FN_W-1] FN_SLT = 11'h02a;

    typedef enum logic [0:2] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_t;

    ////////////////////
    // instruction views
    ////////////////////
    typedef struct packed {
        logic [0:OP_W-1] opcode;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        reg_idx_t        rd;
        logic [0:FN_W-1] func;
    } r_fmt_t;

    // rd sits where r-type keeps rs2
    typedef struct packed {
        logic [0:OP_W-1]  opcode;
        reg_idx_t         rs1;
        reg_idx_t         rd;
        logic [0:IMM_W-1] imm16;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    // all zero word decodes to no write
    localparam instr_t NOP = '0;

    ////////////////////
    // stage payloads
    ////////////////////
    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_write;
        logic    use_imm;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    op_a;
        word_t    op_b;
        word_t    imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     uses_rs2;
    } id_ex_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_to_reg;
        logic     mem_write;
        reg_idx_t rd;
        word_t    alu_result;
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } dmem_req_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    value;
    } wb_t;

endpackage

`default_nettype wire

// File: hw/dlx_regfile.sv
`default_nettype none

module dlx_regfile (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire dlx_pkg::reg_idx_t ra,
    input  wire dlx_pkg::reg_idx_t rb,
    input  wire dlx_pkg::wb_t      wb,
    output dlx_pkg::word_t         rd_a,
    output dlx_pkg::word_t         rd_b
);

    // r0 has no storage
    dlx_pkg::word_t regs [1:dlx_pkg::NUM_REGS-1];

    ////////////////////
    // write port
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < dlx_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we) begin
            // wb.we already low for r0
            regs[wb.rd] <= wb.value;
        end
    end

    ////////////////////
    // read ports
    ////////////////////
    // same-cycle write goes straight through
    always_comb begin
        if (ra == '0) begin
            rd_a = '0;
        end else if (wb.we && (wb.rd == ra)) begin
            rd_a = wb.value;
        end else begin
            rd_a = regs[ra];
        end

        if (rb == '0) begin
            rd_b = '0;
        end else if (wb.we && (wb.rd == rb)) begin
            rd_b = wb.value;
        end else begin
            rd_b = regs[rb];
        end
    end

endmodule

`default_nettype wire

// File: hw/dlx_writeback.sv
`default_nettype none

module dlx_writeback (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire dlx_pkg::ex_mem_t ex_mem,
    input  wire dlx_pkg::word_t   dmem_rdata,
    output dlx_pkg::wb_t          wb
);

    logic              reg_write_q;
    logic              mem_to_reg_q;
    dlx_pkg::reg_idx_t rd_q;
    dlx_pkg::word_t    alu_result_q;
    dlx_pkg::word_t    load_data_q;

    ////////////////////
    // mem/wb register
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_write_q  <= 1'b0;
            mem_to_reg_q <= 1'b0;
        end else begin
            reg_write_q  <= ex_mem.reg_write;
            mem_to_reg_q <= ex_mem.mem_to_reg;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        rd_q         <= ex_mem.rd;
        alu_result_q <= ex_mem.alu_result;
        // memory answers ex_mem address this cycle
        load_data_q  <= dmem_rdata;
    end

    ////////////////////
    // result select
    ////////////////////
    // r0 never written
    assign wb.we    = reg_write_q && (rd_q != '0);
    assign wb.rd    = rd_q;
    assign wb.value = mem_to_reg_q ? load_data_q : alu_result_q;

endmodule

`default_nettype wire

// File: src.f
+incdir+dv
hw/dlx_pkg.sv
hw/dlx_fetch.sv
hw/dlx_decode.sv
hw/dlx_regfile.sv
hw/dlx_execute.sv
hw/dlx_writeback.sv
hw/dlx_core.sv
dv/dlx_tb.sv
